// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= etx_io_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
PASS_MSG  := TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qFx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: filelist.f
+incdir+hw
hw/etx_lane_pkg.sv
hw/etx_cfg_pkg.sv
hw/etx_word_select.sv
hw/etx_lane_serializer.sv
hw/etx_pin_drive.sv
hw/etx_io.sv
tests/etx_io_properties.sv
tests/etx_io_tb.sv

// File: hw/etx_cfg_pkg.sv
//####################
// ETX configuration types
// Output modes and GPIO word layout
//####################

`include "etx_defines.svh"

`default_nettype none

package etx_cfg_pkg;

   //####################
   // Output mode
   //####################
   typedef enum logic [1:0]
   {
      TX_OFF    = 2'd0,      // Lanes released, frame low
      TX_FABRIC = 2'd1,      // Fabric words on the link
      TX_GPIO   = 2'd2       // Constant levels, wins over enable
   } tx_mode_e;

   //####################
   // GPIO setting
   //####################
   // Frame level on top, one level bit per lane below
   typedef logic [`ETX_LANES:0] gpio_word_t;

endpackage

`default_nettype wire

// File: hw/etx_defines.svh
//####################
// ETX transmit pin stage
// Link geometry and synchronizer depth
//####################

`ifndef ETX_DEFINES_SVH
`define ETX_DEFINES_SVH

//####################
// Link geometry
//####################
`define ETX_LANES 8          // Data lanes on the link
`define ETX_SLOTS 8          // Time slots per beat

//####################
// Clock crossing
//####################
`define ETX_SYNC_DEPTH 2     // Flops per synchronizer chain

`endif

// File: hw/etx_io.sv
//####################
// ETX transmit pin stage top
// Word select, data and frame serializers, pin drive
//####################

`timescale 1ns/1ps

`default_nettype none

module etx_io
(
   input  wire                        tx_lclk_out,          // Link clock
   input  wire                        arst_n,               // Async reset, active low
   input  etx_lane_pkg::data_beat_t   tx_data_par,          // Fabric data word
   input  etx_lane_pkg::frame_beat_t  tx_frame_par,         // Fabric frame word
   input  wire                        ecfg_tx_enable,       // Link enable
   input  wire                        ecfg_tx_gpio_enable,  // GPIO mode
   input  etx_cfg_pkg::gpio_word_t    ecfg_dataout,         // GPIO levels
   input  wire                        tx_wr_wait_pin,       // Write wait pin
   input  wire                        tx_rd_wait_pin,       // Read wait pin
   output logic                       tx_par_take,          // Fabric words taken
   output etx_lane_pkg::data_slot_t   tx_data,              // Data lane pins
   output logic                       tx_data_oe,           // Data lane drive enable
   output logic                       tx_frame,             // Frame lane pin
   output logic                       tx_lclk_en,           // Forwarded clock enable
   output logic                       tx_wr_wait,           // Write wait to fabric
   output logic                       tx_rd_wait            // Read wait to fabric
);

   //####################
   // Internal nets
   //####################
   logic                       beat_load;    // Serializer load strobe
   etx_lane_pkg::data_beat_t   data_beat;    // Captured data beat
   etx_lane_pkg::frame_beat_t  frame_beat;   // Captured frame beat
   etx_cfg_pkg::tx_mode_e      tx_mode;      // Synced output mode
   etx_lane_pkg::data_slot_t   data_slot;    // Serial data slot
   etx_lane_pkg::frame_slot_t  frame_slot;   // Serial frame bit

   //####################
   // Word select
   //####################
   etx_word_select u_word_select
   (
      .tx_lclk_out         (tx_lclk_out),
      .arst_n              (arst_n),
      .tx_data_par         (tx_data_par),
      .tx_frame_par        (tx_frame_par),
      .ecfg_tx_enable      (ecfg_tx_enable),
      .ecfg_tx_gpio_enable (ecfg_tx_gpio_enable),
      .ecfg_dataout        (ecfg_dataout),
      .tx_par_take         (tx_par_take),
      .beat_load           (beat_load),
      .data_beat           (data_beat),
      .frame_beat          (frame_beat),
      .tx_mode             (tx_mode)
   );

   //####################
   // Serializers
   //####################
   etx_lane_serializer
   #(
      .beat_t (etx_lane_pkg::data_beat_t),
      .slot_t (etx_lane_pkg::data_slot_t)
   )
   u_data_ser
   (
      .tx_lclk_out (tx_lclk_out),
      .arst_n      (arst_n),
      .beat_load   (beat_load),
      .beat        (data_beat),
      .slot        (data_slot)          // Eight lanes per slot
   );

   etx_lane_serializer
   #(
      .beat_t (etx_lane_pkg::frame_beat_t),
      .slot_t (etx_lane_pkg::frame_slot_t)
   )
   u_frame_ser
   (
      .tx_lclk_out (tx_lclk_out),
      .arst_n      (arst_n),
      .beat_load   (beat_load),
      .beat        (frame_beat),
      .slot        (frame_slot)         // One frame bit per slot
   );

   //####################
   // Pin drive
   //####################
   etx_pin_drive u_pin_drive
   (
      .tx_lclk_out    (tx_lclk_out),
      .arst_n         (arst_n),
      .data_slot      (data_slot),
      .frame_slot     (frame_slot),
      .tx_mode        (tx_mode),
      .ecfg_tx_enable (ecfg_tx_enable),
      .tx_wr_wait_pin (tx_wr_wait_pin),
      .tx_rd_wait_pin (tx_rd_wait_pin),
      .tx_data        (tx_data),
      .tx_data_oe     (tx_data_oe),
      .tx_frame       (tx_frame),
      .tx_lclk_en     (tx_lclk_en),
      .tx_wr_wait     (tx_wr_wait),
      .tx_rd_wait     (tx_rd_wait)
   );

endmodule

`default_nettype wire

// File: hw/etx_lane_pkg.sv
//####################
// ETX lane types
// Pin-side slot and beat layouts for data and frame
//####################

`include "etx_defines.svh"

`default_nettype none

package etx_lane_pkg;

   //####################
   // Data lanes
   //####################
   // Bit i drives lane i
   typedef logic [`ETX_LANES-1:0] data_slot_t;

   // Ascending range puts slot 0 in the top byte
   typedef data_slot_t [0:`ETX_SLOTS-1] data_beat_t;     // 64 bits, slot 0 first out

   //####################
   // Frame lane
   //####################
   typedef logic frame_slot_t;                           // Single frame bit

   typedef frame_slot_t [0:`ETX_SLOTS-1] frame_beat_t;   // Bit 7 of fabric word first out

endpackage

`default_nettype wire

// File: hw/etx_lane_serializer.sv
//####################
// ETX lane serializer
// Loads a beat and shifts out one slot per clock,
// slot 0 first
//####################

`timescale 1ns/1ps

`default_nettype none

module etx_lane_serializer
#(
   parameter type beat_t = logic [7:0],    // Whole beat, slot 0 in the top bits
   parameter type slot_t = logic           // One slot across the lanes
)
(
   input  wire   tx_lclk_out,              // Link clock
   input  wire   arst_n,                   // Async reset, active low
   input  wire   beat_load,                // Load strobe, once per beat
   input  beat_t beat,                     // Beat to send
   output slot_t slot                      // Current slot
);

   localparam int BEAT_W = $bits(beat_t);
   localparam int SLOT_W = $bits(slot_t);

   logic [BEAT_W-1:0] shreg;               // Pending slots, next one on top

   //####################
   // Shift register
   //####################
   always_ff @(posedge tx_lclk_out or negedge arst_n)
   begin
      if (!arst_n)
         shreg <= '0;                       // Idle lanes low out of reset
      else if (beat_load)
         shreg <= beat;                     // Slot 0 shows next cycle
      else
         shreg <= shreg << SLOT_W;          // Advance to later slot
   end

   // Top slot is the one on the wire
   assign slot = slot_t'(shreg[BEAT_W-1 -: SLOT_W]);

endmodule

`default_nettype wire

// File: hw/etx_pin_drive.sv
//####################
// ETX pin drive
// Pin flops, data output enable, link clock
// gating and wait signal return
//####################

`timescale 1ns/1ps

`include "etx_defines.svh"

`default_nettype none

module etx_pin_drive
(
   input  wire                        tx_lclk_out,     // Link clock
   input  wire                        arst_n,          // Async reset, active low
   input  etx_lane_pkg::data_slot_t   data_slot,       // From data serializer
   input  etx_lane_pkg::frame_slot_t  frame_slot,      // From frame serializer
   input  etx_cfg_pkg::tx_mode_e      tx_mode,         // Synced output mode
   input  wire                        ecfg_tx_enable,  // Link enable, async level
   input  wire                        tx_wr_wait_pin,  // Write wait from far end
   input  wire                        tx_rd_wait_pin,  // Read wait from far end
   output etx_lane_pkg::data_slot_t   tx_data,         // Data lane pins
   output logic                       tx_data_oe,      // Data lane drive enable
   output logic                       tx_frame,        // Frame lane pin
   output logic                       tx_lclk_en,      // Forwarded clock enable
   output logic                       tx_wr_wait,      // Synced write wait
   output logic                       tx_rd_wait       // Read wait, straight through
);

   logic [`ETX_SYNC_DEPTH-1:0] lclk_sync;   // Enable chain for clock gate
   logic [`ETX_SYNC_DEPTH-1:0] wr_sync;     // Write wait chain

   //####################
   // Lane pins
   //####################
   always_ff @(posedge tx_lclk_out or negedge arst_n)
   begin
      if (!arst_n)
      begin
         tx_data  <= '0;
         tx_frame <= 1'b0;
      end
      else
      begin
         tx_data  <= data_slot;               // One slot per clock
         tx_frame <= frame_slot;
      end
   end

   // Release data lanes when link is off
   assign tx_data_oe = (tx_mode != etx_cfg_pkg::TX_OFF);

   //####################
   // Link clock gate
   //####################
   always_ff @(posedge tx_lclk_out or negedge arst_n)
   begin
      if (!arst_n)
      begin
         lclk_sync  <= '0;
         tx_lclk_en <= 1'b0;
      end
      else
      begin
         lclk_sync  <= {lclk_sync[`ETX_SYNC_DEPTH-2:0], ecfg_tx_enable};
         tx_lclk_en <= lclk_sync[`ETX_SYNC_DEPTH-1];   // Extra stage as output flop
      end
   end

   //####################
   // Wait return
   //####################
   always_ff @(posedge tx_lclk_out or negedge arst_n)
   begin
      if (!arst_n)
         wr_sync <= '0;
      else
         wr_sync <= {wr_sync[`ETX_SYNC_DEPTH-2:0], tx_wr_wait_pin};
   end

   assign tx_wr_wait = wr_sync[`ETX_SYNC_DEPTH-1];   // Two edges behind the pin
   assign tx_rd_wait = tx_rd_wait_pin;               // Single-ended, no sync needed

endmodule

`default_nettype wire

// File: hw/etx_word_select.sv
//####################
// ETX word select
// Syncs mode bits, counts slots and registers
// the fabric, GPIO or zero word once per beat
//####################

`timescale 1ns/1ps

`include "etx_defines.svh"

`default_nettype none

module etx_word_select
(
   input  wire                        tx_lclk_out,          // Link clock
   input  wire                        arst_n,               // Async reset, active low
   input  etx_lane_pkg::data_beat_t   tx_data_par,          // Fabric data word
   input  etx_lane_pkg::frame_beat_t  tx_frame_par,         // Fabric frame word
   input  wire                        ecfg_tx_enable,       // Link enable, async level
   input  wire                        ecfg_tx_gpio_enable,  // GPIO mode, async level
   input  etx_cfg_pkg::gpio_word_t    ecfg_dataout,         // GPIO levels
   output logic                       tx_par_take,          // Fabric words sampled this edge
   output logic                       beat_load,            // Serializer load strobe
   output etx_lane_pkg::data_beat_t   data_beat,            // Captured data beat
   output etx_lane_pkg::frame_beat_t  frame_beat,           // Captured frame beat
   output etx_cfg_pkg::tx_mode_e      tx_mode               // Synced output mode
);

   localparam int CNT_W = $clog2(`ETX_SLOTS);
   localparam logic [CNT_W-1:0] LAST_SLOT = CNT_W'(`ETX_SLOTS - 1);

   logic [`ETX_SYNC_DEPTH-1:0] en_sync;         // Enable chain, top bit is safe
   logic [`ETX_SYNC_DEPTH-1:0] gpio_sync;       // GPIO chain, top bit is safe
   logic [CNT_W-1:0]           slot_cnt;        // Slot within current beat
   etx_lane_pkg::data_beat_t   gpio_data;       // Lane byte in every slot
   etx_lane_pkg::frame_beat_t  gpio_frame;      // Frame level in every slot

   //####################
   // Mode synchronizers
   //####################
   always_ff @(posedge tx_lclk_out or negedge arst_n)
   begin
      if (!arst_n)
      begin
         en_sync   <= '0;
         gpio_sync <= '0;
      end
      else
      begin
         en_sync   <= {en_sync[`ETX_SYNC_DEPTH-2:0], ecfg_tx_enable};       // Shift in
         gpio_sync <= {gpio_sync[`ETX_SYNC_DEPTH-2:0], ecfg_tx_gpio_enable};
      end
   end

   // GPIO overrides enable
   always_comb
   begin
      if (gpio_sync[`ETX_SYNC_DEPTH-1])
         tx_mode = etx_cfg_pkg::TX_GPIO;
      else if (en_sync[`ETX_SYNC_DEPTH-1])
         tx_mode = etx_cfg_pkg::TX_FABRIC;
      else
         tx_mode = etx_cfg_pkg::TX_OFF;
   end

   //####################
   // Slot counter
   //####################
   always_ff @(posedge tx_lclk_out or negedge arst_n)
   begin
      if (!arst_n)
         slot_cnt <= '0;
      else if (slot_cnt == LAST_SLOT)
         slot_cnt <= '0;                       // Wrap to next beat
      else
         slot_cnt <= slot_cnt + 1'b1;
   end

   assign tx_par_take = (slot_cnt == LAST_SLOT);  // Last slot, fabric sampled at its edge

   // Serializers load one cycle after capture
   always_ff @(posedge tx_lclk_out or negedge arst_n)
   begin
      if (!arst_n)
         beat_load <= 1'b0;
      else
         beat_load <= tx_par_take;
   end

   //####################
   // Beat capture
   //####################
   assign gpio_data  = {`ETX_SLOTS{ecfg_dataout[`ETX_LANES-1:0]}};  // Same byte each slot
   assign gpio_frame = {`ETX_SLOTS{ecfg_dataout[`ETX_LANES]}};      // Constant frame level

   always_ff @(posedge tx_lclk_out)
   begin
      if (tx_par_take)
      begin
         case (tx_mode)
            etx_cfg_pkg::TX_FABRIC:
            begin
               data_beat  <= tx_data_par;
               frame_beat <= tx_frame_par;
            end
            etx_cfg_pkg::TX_GPIO:
            begin
               data_beat  <= gpio_data;
               frame_beat <= gpio_frame;
            end
            default:
            begin
               data_beat  <= '0;                  // Quiet lanes when off
               frame_beat <= '0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: tests/etx_io_properties.sv
//####################
// ETX pin stage assertions
// Beat load spacing, drive enable and quiet lanes
// when off, quiet outputs during reset
//####################

`timescale 1ns/1ps

`include "etx_defines.svh"

`default_nettype none

module etx_io_properties
#(
   parameter bit CHECK_LOAD = 1'b0,             // Watch serializer load strobe
   parameter bit CHECK_PINS = 1'b0              // Watch pin outputs
)
(
   input wire                      tx_lclk_out,  // Link clock
   input wire                      arst_n,       // Async reset, active low
   input wire                      beat_load,    // Serializer load strobe
   input etx_cfg_pkg::tx_mode_e    tx_mode,      // Synced output mode
   input wire                      tx_data_oe,   // Data lane drive enable
   input wire [`ETX_LANES-1:0]     tx_data,      // Data lane pins
   input wire                      tx_frame,     // Frame lane pin
   input wire                      tx_lclk_en    // Forwarded clock enable
);

   // Take, load and pin flop after the mode goes off
   localparam logic [3:0] QUIET_RUN = 4'(`ETX_SLOTS + 2);

   logic [3:0] load_gap;                        // Cycles since last load
   logic       seen_load;                       // First load has happened
   logic [3:0] off_run;                         // Edges in a row with link off

   always_ff @(posedge tx_lclk_out or negedge arst_n)
   begin
      if (!arst_n)
      begin
         load_gap  <= '0;
         seen_load <= 1'b0;
      end
      else if (beat_load)
      begin
         load_gap  <= 4'd1;                      // Restart gap count
         seen_load <= 1'b1;
      end
      else
         load_gap <= load_gap + 1'b1;
   end

   always_ff @(posedge tx_lclk_out or negedge arst_n)
   begin
      if (!arst_n)
         off_run <= '0;
      else if (tx_mode != etx_cfg_pkg::TX_OFF)
         off_run <= '0;                          // Link back on
      else if (off_run != 4'hf)
         off_run <= off_run + 1'b1;              // Saturate
   end

   //####################
   // Load spacing
   //####################
   if (CHECK_LOAD)
   begin : g_load
      assert property (@(posedge tx_lclk_out) disable iff (!arst_n)
         (seen_load && beat_load) |-> (load_gap == 4'(`ETX_SLOTS)))
         else $error("beat_load arrived off its beat spacing");
      assert property (@(posedge tx_lclk_out) disable iff (!arst_n)
         (seen_load && load_gap == 4'(`ETX_SLOTS)) |-> beat_load)
         else $error("beat_load missing at end of beat");
   end

   //####################
   // Pin behavior
   //####################
   if (CHECK_PINS)
   begin : g_pins
      assert property (@(posedge tx_lclk_out) disable iff (!arst_n)
         (tx_mode == etx_cfg_pkg::TX_OFF) |->
            (!tx_data_oe && (off_run < QUIET_RUN || (tx_data == '0 && !tx_frame))))
         else $error("data or frame lanes active while link is off");
      assert property (@(posedge tx_lclk_out)
         !arst_n |-> (tx_data == '0 && !tx_frame && !tx_lclk_en && !tx_data_oe))
         else $error("pin outputs active during reset");
   end

endmodule

// Load strobe lives in word select
bind etx_word_select etx_io_properties
#(
   .CHECK_LOAD (1'b1),
   .CHECK_PINS (1'b0)
)
u_select_props
(
   .tx_lclk_out (tx_lclk_out),
   .arst_n      (arst_n),
   .beat_load   (beat_load),
   .tx_mode     (tx_mode),
   .tx_data_oe  (1'b0),
   .tx_data     ('0),
   .tx_frame    (1'b0),
   .tx_lclk_en  (1'b0)
);

// Pin flops and enables live in pin drive
bind etx_pin_drive etx_io_properties
#(
   .CHECK_LOAD (1'b0),
   .CHECK_PINS (1'b1)
)
u_pin_props
(
   .tx_lclk_out (tx_lclk_out),
   .arst_n      (arst_n),
   .beat_load   (1'b0),
   .tx_mode     (tx_mode),
   .tx_data_oe  (tx_data_oe),
   .tx_data     (tx_data),
   .tx_frame    (tx_frame),
   .tx_lclk_en  (tx_lclk_en)
);

`default_nettype wire

// File: tests/etx_io_tb.sv
//####################
// ETX transmit pin stage testbench
// Mode table applied in a loop, pins compared
// slot by slot with the words seen at each take
//####################

`timescale 1ns/1ps

`include "etx_defines.svh"

`default_nettype none

module etx_io_tb;

   localparam int CLK_PERIOD   = 4;                   // ns
   localparam int NUM_ROWS     = 7;
   localparam int SETTLE_BEATS = 3;                   // Beats after a mode change
   localparam int WAIT_CYCLES  = 24;                  // Wait pin phase length
   localparam int BEAT_W       = `ETX_LANES * `ETX_SLOTS;

   typedef struct packed
   {
      logic       en;                                 // Link enable
      logic       gpio;                               // GPIO mode
      logic [8:0] gpio_word;                          // Frame level and lane levels
      logic [7:0] beats;                              // Checked beats
   } row_t;

   row_t rows [NUM_ROWS];

   logic                  tx_lclk_out;
   logic                  arst_n;
   logic [BEAT_W-1:0]     tx_data_par;
   logic [`ETX_SLOTS-1:0] tx_frame_par;
   logic                  ecfg_tx_enable;
   logic                  ecfg_tx_gpio_enable;
   logic [`ETX_LANES:0]   ecfg_dataout;
   logic                  tx_wr_wait_pin;
   logic                  tx_rd_wait_pin;
   wire                   tx_par_take;
   wire  [`ETX_LANES-1:0] tx_data;
   wire                   tx_data_oe;
   wire                   tx_frame;
   wire                   tx_lclk_en;
   wire                   tx_wr_wait;
   wire                   tx_rd_wait;

   int                    ncyc = 0;                   // Negedge count
   int                    last_take = -1;             // Negedge of previous take
   int                    slots_checked = 0;
   bit                    settled = 1'b0;             // Mode stable, pins checkable
   int                    exp_due   [$];              // Negedge each slot is due
   logic [`ETX_LANES-1:0] exp_data  [$];
   logic                  exp_frame [$];
   bit                    exp_chk   [$];

   //####################
   // Clock and DUT
   //####################
   initial tx_lclk_out = 1'b0;
   always #(CLK_PERIOD/2) tx_lclk_out = ~tx_lclk_out;

   etx_io etx_io_i
   (
      .tx_lclk_out         (tx_lclk_out),
      .arst_n              (arst_n),
      .tx_data_par         (tx_data_par),
      .tx_frame_par        (tx_frame_par),
      .ecfg_tx_enable      (ecfg_tx_enable),
      .ecfg_tx_gpio_enable (ecfg_tx_gpio_enable),
      .ecfg_dataout        (ecfg_dataout),
      .tx_wr_wait_pin      (tx_wr_wait_pin),
      .tx_rd_wait_pin      (tx_rd_wait_pin),
      .tx_par_take         (tx_par_take),
      .tx_data             (tx_data),
      .tx_data_oe          (tx_data_oe),
      .tx_frame            (tx_frame),
      .tx_lclk_en          (tx_lclk_en),
      .tx_wr_wait          (tx_wr_wait),
      .tx_rd_wait          (tx_rd_wait)
   );

   //####################
   // Helpers
   //####################
   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      begin
         if (got !== exp)
         begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Stopping at first mismatch");
         end
      end
   endtask

   // GPIO wins, then fabric, else quiet lanes
   function automatic logic [`ETX_LANES-1:0] slot_data(input logic en, input logic gpio,
      input logic [`ETX_LANES:0] gword, input logic [BEAT_W-1:0] word, input int k);
      if (gpio)
         return gword[`ETX_LANES-1:0];
      else if (en)
         return word[BEAT_W-1-`ETX_LANES*k -: `ETX_LANES];    // Slot 0 in top byte
      else
         return '0;
   endfunction

   function automatic logic slot_frame(input logic en, input logic gpio,
      input logic [`ETX_LANES:0] gword, input logic [`ETX_SLOTS-1:0] frame, input int k);
      if (gpio)
         return gword[`ETX_LANES];
      else if (en)
         return frame[`ETX_SLOTS-1-k];                         // Bit 7 first
      else
         return 1'b0;
   endfunction

   task automatic load_table();
      begin
         //        en    gpio  gpio_word  beats
         rows[0] = '{1'b1, 1'b0, 9'h000, 8'd6};   // Fabric
         rows[1] = '{1'b1, 1'b1, 9'h1a5, 8'd4};   // GPIO over enable
         rows[2] = '{1'b0, 1'b0, 9'h0ff, 8'd4};   // Off
         rows[3] = '{1'b1, 1'b0, 9'h000, 8'd6};   // Re-enable
         rows[4] = '{1'b0, 1'b1, 9'h03c, 8'd4};   // GPIO alone
         rows[5] = '{1'b1, 1'b0, 9'h000, 8'd5};
         rows[6] = '{1'b0, 1'b0, 9'h100, 8'd3};
      end
   endtask

   task automatic new_words();
      begin
         tx_data_par  = {$urandom, $urandom};
         tx_frame_par = 8'($urandom);
      end
   endtask

   task automatic wait_take();
      begin
         do
            @(negedge tx_lclk_out);
         while (!tx_par_take);
      end
   endtask

   task automatic run_beats(input int n);
      begin
         repeat (n)
         begin
            wait_take();
            @(posedge tx_lclk_out);
            #1;
            new_words();                                       // Next fabric word
         end
      end
   endtask

   task automatic check_idle_pins();
      begin
         check_val("tx_par_take", 64'(tx_par_take), 64'd0);
         check_val("tx_data", 64'(tx_data), 64'd0);
         check_val("tx_data_oe", 64'(tx_data_oe), 64'd0);
         check_val("tx_frame", 64'(tx_frame), 64'd0);
         check_val("tx_lclk_en", 64'(tx_lclk_en), 64'd0);
      end
   endtask

   task automatic apply_row(input row_t r);
      logic was_off;
      begin
         was_off = !ecfg_tx_enable;
         wait_take();
         @(posedge tx_lclk_out);
         #1;
         settled             = 1'b0;
         ecfg_tx_enable      = r.en;
         ecfg_tx_gpio_enable = r.gpio;
         ecfg_dataout        = r.gpio_word;
         new_words();
         if (was_off && r.en)
         begin
            repeat (`ETX_SYNC_DEPTH + 1) @(posedge tx_lclk_out);
            #1;
            check_val("tx_lclk_en", 64'(tx_lclk_en), 64'd1);   // Clock back on
         end
         run_beats(SETTLE_BEATS);
         check_val("tx_data_oe", 64'(tx_data_oe), 64'(r.en | r.gpio));
         check_val("tx_lclk_en", 64'(tx_lclk_en), 64'(r.en));
         settled = 1'b1;
         run_beats(int'(r.beats));
      end
   endtask

   task automatic check_waits();
      logic wr_hist [$];
      logic rd_now;
      begin
         for (int n = 0; n < WAIT_CYCLES; n++)
         begin
            @(posedge tx_lclk_out);
            #1;
            tx_wr_wait_pin = 1'($urandom);
            rd_now         = 1'($urandom);
            tx_rd_wait_pin = rd_now;
            wr_hist.push_back(tx_wr_wait_pin);
            #1;
            check_val("tx_rd_wait", 64'(tx_rd_wait), 64'(rd_now));       // Same cycle
            if (n >= 2)
               check_val("tx_wr_wait", 64'(tx_wr_wait), 64'(wr_hist[n-2]));
         end
      end
   endtask

   //####################
   // Pin capture
   //####################
   initial
   begin
      forever
      begin
         @(negedge tx_lclk_out);
         ncyc = ncyc + 1;
         if (arst_n && tx_par_take)
         begin
            if (last_take >= 0)
               check_val("take_spacing", 64'(ncyc - last_take), 64'(`ETX_SLOTS));
            last_take = ncyc;
            for (int k = 0; k < `ETX_SLOTS; k++)
            begin
               exp_due.push_back(ncyc + 3 + k);                 // Pins after E+2+k
               exp_data.push_back(slot_data(ecfg_tx_enable, ecfg_tx_gpio_enable,
                  ecfg_dataout, tx_data_par, k));
               exp_frame.push_back(slot_frame(ecfg_tx_enable, ecfg_tx_gpio_enable,
                  ecfg_dataout, tx_frame_par, k));
               exp_chk.push_back(settled);
            end
         end
         if (exp_due.size() > 0 && exp_due[0] == ncyc)
         begin
            if (exp_chk[0])
            begin
               check_val("tx_data", 64'(tx_data), 64'(exp_data[0]));
               check_val("tx_frame", 64'(tx_frame), 64'(exp_frame[0]));
               slots_checked = slots_checked + 1;
            end
            void'(exp_due.pop_front());
            void'(exp_data.pop_front());
            void'(exp_frame.pop_front());
            void'(exp_chk.pop_front());
         end
      end
   end

   //####################
   // Watchdog
   //####################
   initial
   begin
      int total_beats;
      total_beats = 0;
      #1;
      for (int i = 0; i < NUM_ROWS; i++)
         total_beats = total_beats + int'(rows[i].beats) + SETTLE_BEATS + 1;
      #((total_beats * `ETX_SLOTS + WAIT_CYCLES + 100) * CLK_PERIOD);
      $display("Watchdog expired before the test sequence finished");
      $display("TEST FAILED");
      $fatal(1, "Simulation timed out");
   end

   //####################
   // Main sequence
   //####################
   initial
   begin
      void'($urandom(22837));
      load_table();
      arst_n              = 1'b1;
      tx_data_par         = '0;
      tx_frame_par        = '0;
      ecfg_tx_enable      = 1'b0;
      ecfg_tx_gpio_enable = 1'b0;
      ecfg_dataout        = '0;
      tx_wr_wait_pin      = 1'b0;
      tx_rd_wait_pin      = 1'b0;
      #1 arst_n = 1'b0;
      repeat (3)
      begin
         @(posedge tx_lclk_out);
         #1;
         check_idle_pins();                                    // Held in reset
      end
      arst_n = 1'b1;
      @(negedge tx_lclk_out);
      check_idle_pins();                                       // Just out of reset
      for (int i = 0; i < NUM_ROWS; i++)
         apply_row(rows[i]);
      check_waits();
      repeat (3 * `ETX_SLOTS) @(negedge tx_lclk_out);         // Drain pending slots
      if (slots_checked > 0)
      begin
         $display("TEST PASSED");
         $finish;
      end
      else
      begin
         $display("No pin slots were compared against expected values");
         $display("TEST FAILED");
         $fatal(1, "Pin capture never ran");
      end
   end

endmodule

`default_nettype wire
